//--- logic/gemm_dims_pkg.sv
package gemm_dims_pkg;

    // tile geometry
    localparam int TILE_M = 2;
    localparam int TILE_N = 2;
    localparam int TILE_K = 2;

    // blocks along each dimension
    localparam int BLK_M = 2;
    localparam int BLK_N = 2;
    localparam int BLK_K = 2;

    // element widths
    localparam int A_W   = 8;   // activation, signed
    localparam int B_W   = 4;   // weight, signed
    localparam int ACC_W = 32;  // accumulator, wraps

    // buffer sizes
    localparam int P_DEPTH = BLK_M * BLK_K;
    localparam int Q_DEPTH = BLK_N * BLK_K;
    localparam int R_DEPTH = BLK_M * BLK_N;

    localparam int P_AW = $clog2(P_DEPTH);
    localparam int Q_AW = $clog2(Q_DEPTH);
    localparam int R_AW = $clog2(R_DEPTH);

    // registered levels of the reduction over kk
    localparam int TREE_LVL = $clog2(TILE_K);

    // element (m, kk) at m*TILE_K + kk
    typedef logic [TILE_M*TILE_K-1:0][A_W-1:0] a_tile_t;

    // element (n, kk) at n*TILE_K + kk
    typedef logic [TILE_N*TILE_K-1:0][B_W-1:0] b_tile_t;

    // element (m, n) at m*TILE_N + n
    typedef logic [TILE_M*TILE_N-1:0][ACC_W-1:0] c_tile_t;

    typedef logic [P_AW-1:0] p_addr_t;  // {i, k}
    typedef logic [Q_AW-1:0] q_addr_t;  // {j, k}
    typedef logic [R_AW-1:0] r_addr_t;  // {i, j}

endpackage

//--- logic/gemm_ctrl_pkg.sv
package gemm_ctrl_pkg;

    import gemm_dims_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT       = 2'd0,
        ST_WORK       = 2'd1,
        ST_WRITE_BACK = 2'd2
    } engine_state_t;

    // host write ports
    typedef struct packed {
        logic    en;
        p_addr_t addr;
        a_tile_t data;
    } p_wr_t;

    typedef struct packed {
        logic    en;
        q_addr_t addr;
        b_tile_t data;
    } q_wr_t;

    typedef struct packed {
        logic    en;
        r_addr_t addr;
        c_tile_t data;
    } r_wr_t;

    typedef struct packed {
        logic    en;
        r_addr_t addr;
    } r_rd_t;

    localparam int TOTAL_STEPS = BLK_M * BLK_N * BLK_K;
    localparam int MAC_LATENCY = 2 + TREE_LVL;  // products, tree, accumulate
    localparam int RUN_CYCLES  = TOTAL_STEPS + MAC_LATENCY + 2;

    // step counter fields, k runs fastest
    localparam int BI_W = $clog2(BLK_M);
    localparam int BJ_W = $clog2(BLK_N);
    localparam int BK_W = $clog2(BLK_K);

    typedef struct packed {
        logic [BI_W-1:0] i;
        logic [BJ_W-1:0] j;
        logic [BK_W-1:0] k;
    } step_t;

endpackage

//--- logic/tile_buffer.sv
`timescale 1ns/1ps

module tile_buffer #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [DATA_W-1:0]        wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [DATA_W-1:0]        rd_data,
    output logic                     rd_valid
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // old data on same-address collision
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

//--- logic/tile_mac.sv
`timescale 1ns/1ps

module tile_mac (
    input  logic                   clk,
    input  logic                   rst,
    input  gemm_dims_pkg::a_tile_t a_tile,
    input  gemm_dims_pkg::b_tile_t b_tile,
    input  logic                   opnd_valid,
    input  logic                   last_k,
    input  gemm_dims_pkg::c_tile_t c_tile,
    input  logic                   c_valid,
    output gemm_dims_pkg::c_tile_t acc_tile,
    output logic                   acc_valid
);

    import gemm_dims_pkg::*;

    // per output element a binary heap, leaves at TILE_K-1 .. 2*TILE_K-2, root at 0
    logic signed [ACC_W-1:0] node [TILE_M][TILE_N][2*TILE_K-1];

    // one flag bit per registered level, products at bit 0
    logic [TREE_LVL:0] vld_pipe;
    logic [TREE_LVL:0] last_pipe;

    // products into the leaves, pairwise sums up the heap
    always_ff @(posedge clk) begin
        for (int m = 0; m < TILE_M; m++) begin
            for (int n = 0; n < TILE_N; n++) begin
                for (int kk = 0; kk < TILE_K; kk++) begin
                    node[m][n][TILE_K-1+kk] <= $signed(a_tile[m*TILE_K+kk])
                                             * $signed(b_tile[n*TILE_K+kk]);
                end
                for (int x = 0; x < TILE_K - 1; x++) begin
                    node[m][n][x] <= node[m][n][2*x+1] + node[m][n][2*x+2];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe  <= '0;
            last_pipe <= '0;
            acc_valid <= 1'b0;
        end else begin
            vld_pipe[0]  <= opnd_valid;
            last_pipe[0] <= opnd_valid & last_k;
            for (int l = 1; l <= TREE_LVL; l++) begin
                vld_pipe[l]  <= vld_pipe[l-1];
                last_pipe[l] <= last_pipe[l-1];
            end
            acc_valid <= vld_pipe[TREE_LVL] & last_pipe[TREE_LVL];
        end
    end

    // R data arrives only with the first k of a block
    always_ff @(posedge clk) begin
        if (vld_pipe[TREE_LVL]) begin
            for (int m = 0; m < TILE_M; m++) begin
                for (int n = 0; n < TILE_N; n++) begin
                    if (c_valid) begin
                        acc_tile[m*TILE_N+n] <= c_tile[m*TILE_N+n] + node[m][n][0];
                    end else begin
                        acc_tile[m*TILE_N+n] <= acc_tile[m*TILE_N+n] + node[m][n][0];
                    end
                end
            end
        end
    end

endmodule

//--- logic/block_sequencer.sv
`timescale 1ns/1ps

module block_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  gemm_ctrl_pkg::r_wr_t   host_r_wr,
    input  gemm_ctrl_pkg::r_rd_t   host_r_rd,
    input  gemm_dims_pkg::c_tile_t acc_tile,
    input  logic                   acc_valid,
    output logic                   p_rd_en,
    output gemm_dims_pkg::p_addr_t p_rd_addr,
    output logic                   q_rd_en,
    output gemm_dims_pkg::q_addr_t q_rd_addr,
    output gemm_ctrl_pkg::r_wr_t   r_wr,
    output gemm_ctrl_pkg::r_rd_t   r_rd,
    output logic                   last_k,
    output logic                   busy,
    output logic                   done
);

    import gemm_dims_pkg::*;
    import gemm_ctrl_pkg::*;

    engine_state_t state;
    step_t         step;
    logic          working;

    r_rd_t         rd_req;
    r_rd_t         rd_pipe [MAC_LATENCY-1];
    r_rd_t         eng_rd;

    logic          wb_en;
    r_addr_t       wb_addr;
    c_tile_t       wb_data;
    r_addr_t       wb_cnt;
    r_wr_t         eng_wr;

    assign working = (state == ST_WORK);
    assign busy    = (state != ST_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_WAIT;
            step  <= '0;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (start) begin
                        state <= ST_WORK;
                        step  <= '0;
                    end
                end
                ST_WORK: begin
                    step <= step + 1'b1;
                    if (step == $bits(step_t)'(TOTAL_STEPS - 1)) begin
                        state <= ST_WRITE_BACK;
                    end
                end
                ST_WRITE_BACK: begin
                    if (done) begin  // last tile goes out on this edge
                        state <= ST_WAIT;
                    end
                end
                default: state <= ST_WAIT;
            endcase
        end
    end

    // one P/Q read per step
    assign p_rd_en   = working;
    assign q_rd_en   = working;
    assign p_rd_addr = {step.i, step.k};
    assign q_rd_addr = {step.j, step.k};

    always_comb begin
        rd_req.en   = working && (step.k == '0);
        rd_req.addr = {step.i, step.j};
    end

    // R read lines up with the block's first partial sum
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < MAC_LATENCY - 1; d++) begin
                rd_pipe[d] <= '0;
            end
            last_k <= 1'b0;
        end else begin
            rd_pipe[0] <= rd_req;
            for (int d = 1; d < MAC_LATENCY - 1; d++) begin
                rd_pipe[d] <= rd_pipe[d-1];
            end
            last_k <= working && (step.k == BK_W'(BLK_K - 1));  // same cycle as operands
        end
    end

    assign eng_rd = rd_pipe[MAC_LATENCY-2];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en  <= 1'b0;
            wb_cnt <= '0;
            done   <= 1'b0;
        end else begin
            wb_en <= acc_valid;
            done  <= acc_valid && (wb_cnt == r_addr_t'(R_DEPTH - 1));
            if (acc_valid) begin
                wb_cnt <= wb_cnt + 1'b1;  // wraps for the next run
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            wb_addr <= wb_cnt;
            wb_data <= acc_tile;
        end
    end

    assign eng_wr = '{en: wb_en, addr: wb_addr, data: wb_data};

    // host owns the R port while idle
    always_comb begin
        if (busy) begin
            r_wr = eng_wr;
            r_rd = eng_rd;
        end else begin
            r_wr = host_r_wr;
            r_rd = host_r_rd;
        end
    end

endmodule

//--- logic/gemm_top.sv
`timescale 1ns/1ps

module gemm_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  gemm_ctrl_pkg::p_wr_t   p_wr,
    input  gemm_ctrl_pkg::q_wr_t   q_wr,
    input  gemm_ctrl_pkg::r_wr_t   r_wr,
    input  gemm_ctrl_pkg::r_rd_t   r_rd,
    output logic                   busy,
    output logic                   done,
    output gemm_dims_pkg::c_tile_t c_out,
    output logic                   c_valid
);

    import gemm_dims_pkg::*;
    import gemm_ctrl_pkg::*;

    logic    p_rd_en;
    p_addr_t p_rd_addr;
    a_tile_t a_tile;
    logic    p_valid;

    logic    q_rd_en;
    q_addr_t q_rd_addr;
    b_tile_t b_tile;
    logic    q_valid;

    r_wr_t   buf_r_wr;
    r_rd_t   buf_r_rd;
    c_tile_t r_data;
    logic    r_valid;

    c_tile_t acc_tile;
    logic    acc_valid;
    logic    last_k;

    tile_buffer #(.DATA_W($bits(a_tile_t)), .DEPTH(P_DEPTH)) u_p_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (p_wr.en),
        .wr_addr (p_wr.addr),
        .wr_data (p_wr.data),
        .rd_en   (p_rd_en),
        .rd_addr (p_rd_addr),
        .rd_data (a_tile),
        .rd_valid(p_valid)
    );

    tile_buffer #(.DATA_W($bits(b_tile_t)), .DEPTH(Q_DEPTH)) u_q_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (q_wr.en),
        .wr_addr (q_wr.addr),
        .wr_data (q_wr.data),
        .rd_en   (q_rd_en),
        .rd_addr (q_rd_addr),
        .rd_data (b_tile),
        .rd_valid(q_valid)
    );

    tile_buffer #(.DATA_W($bits(c_tile_t)), .DEPTH(R_DEPTH)) u_r_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (buf_r_wr.en),
        .wr_addr (buf_r_wr.addr),
        .wr_data (buf_r_wr.data),
        .rd_en   (buf_r_rd.en),
        .rd_addr (buf_r_rd.addr),
        .rd_data (r_data),
        .rd_valid(r_valid)
    );

    tile_mac u_mac (
        .clk       (clk),
        .rst       (rst),
        .a_tile    (a_tile),
        .b_tile    (b_tile),
        .opnd_valid(p_valid & q_valid),
        .last_k    (last_k),
        .c_tile    (r_data),
        .c_valid   (r_valid),
        .acc_tile  (acc_tile),
        .acc_valid (acc_valid)
    );

    block_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .host_r_wr(r_wr),
        .host_r_rd(r_rd),
        .acc_tile (acc_tile),
        .acc_valid(acc_valid),
        .p_rd_en  (p_rd_en),
        .p_rd_addr(p_rd_addr),
        .q_rd_en  (q_rd_en),
        .q_rd_addr(q_rd_addr),
        .r_wr     (buf_r_wr),
        .r_rd     (buf_r_rd),
        .last_k   (last_k),
        .busy     (busy),
        .done     (done)
    );

    // engine's own R reads stay internal
    always_comb begin
        if (busy) begin
            c_out   = '0;
            c_valid = 1'b0;
        end else begin
            c_out   = r_data;
            c_valid = r_valid;
        end
    end

endmodule

//--- tests/gemm_top_properties.sv
`timescale 1ns/1ps

module gemm_top_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input gemm_ctrl_pkg::r_rd_t r_rd,
    input logic                 busy,
    input logic                 done,
    input logic                 c_valid
);

    import gemm_ctrl_pkg::*;

    // one-cycle done pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else $error("done held longer than one cycle");

    // readout only answers a host read made while idle
    a_readout_source: assert property (
        @(posedge clk) disable iff (rst) c_valid |-> !busy && $past(r_rd.en && !busy)
    ) else $error("c_valid without an idle host read or while busy");

    a_done_latency: assert property (
        @(posedge clk) disable iff (rst) (start && !busy) |-> ##RUN_CYCLES done
    ) else $error("done missing at fixed latency after start");

    a_idle_after_reset: assert property (
        @(posedge clk) rst |=> !busy
    ) else $error("busy high right after reset");

endmodule

bind gemm_top gemm_top_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .r_rd   (r_rd),
    .busy   (busy),
    .done   (done),
    .c_valid(c_valid)
);

//--- tests/gemm_top_tb.sv
`timescale 1ns/1ps

module gemm_top_tb;

    import gemm_dims_pkg::*;
    import gemm_ctrl_pkg::*;

    localparam int NUM_CASES   = 4;
    localparam int CASE_WORDS  = 8;    // P, Q, R init x2, run 1 x2, run 2 x2
    localparam int CLK_PERIOD  = 20;
    localparam int LOAD_CYCLES = R_DEPTH + 2;
    localparam int READ_CYCLES = 3 * 2 * R_DEPTH;
    localparam int CASE_CYCLES = LOAD_CYCLES + 2 * (RUN_CYCLES + 4) + READ_CYCLES + 20;
    localparam int TIMEOUT_NS  = (NUM_CASES * CASE_CYCLES + 20) * CLK_PERIOD;

    logic    clk;
    logic    rst;
    logic    start;
    p_wr_t   p_wr;
    q_wr_t   q_wr;
    r_wr_t   r_wr;
    r_rd_t   r_rd;
    logic    busy;
    logic    done;
    c_tile_t c_out;
    logic    c_valid;

    logic [255:0] cases_mem [NUM_CASES*CASE_WORDS];
    int errors;
    int checks;

    gemm_top u_gemm_top (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .p_wr   (p_wr),
        .q_wr   (q_wr),
        .r_wr   (r_wr),
        .r_rd   (r_rd),
        .busy   (busy),
        .done   (done),
        .c_out  (c_out),
        .c_valid(c_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out before all cases finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // one entry of each buffer per cycle
    task automatic load_case(input int base);
        for (int e = 0; e < R_DEPTH; e++) begin
            @(posedge clk);
            #2;
            p_wr.en   = 1'b1;
            p_wr.addr = p_addr_t'(e);
            p_wr.data = cases_mem[base][32*e +: 32];
            q_wr.en   = 1'b1;
            q_wr.addr = q_addr_t'(e);
            q_wr.data = cases_mem[base+1][16*e +: 16];
            r_wr.en   = 1'b1;
            r_wr.addr = r_addr_t'(e);
            r_wr.data = cases_mem[base+2+e/2][128*(e%2) +: 128];
        end
        @(posedge clk);
        #2;
        p_wr = '0;
        q_wr = '0;
        r_wr = '0;
    endtask

    task automatic read_r(input r_addr_t addr, output c_tile_t data);
        @(posedge clk);
        #2;
        r_rd.en   = 1'b1;
        r_rd.addr = addr;
        @(posedge clk);
        #2;
        r_rd = '0;
        @(negedge clk);
        checks++;
        if (c_valid !== 1'b1) begin
            errors++;
            $display("ERR c_valid R[%0d] got %h exp %h", addr, c_valid, 1'b1);
        end
        data = c_out;
    endtask

    task automatic compare_r(input int word, input string what);
        c_tile_t got;
        c_tile_t exp;
        for (int e = 0; e < R_DEPTH; e++) begin
            read_r(r_addr_t'(e), got);
            exp = cases_mem[word+e/2][128*(e%2) +: 128];
            checks++;
            if (got !== exp) begin
                errors++;
                $display("ERR c_out R[%0d] %s got %h exp %h", e, what, got, exp);
            end
        end
    endtask

    // start, then a stray start and a host read in mid run
    task automatic run_engine();
        int cnt;
        int done_at;
        cnt     = 0;
        done_at = 0;
        @(posedge clk);
        #2;
        start = 1'b1;
        while (done_at == 0 && cnt < RUN_CYCLES + 8) begin
            @(posedge clk);
            #2;
            cnt++;
            start     = (cnt == 4);
            r_rd.en   = (cnt == 4);
            r_rd.addr = r_addr_t'(2);
            @(negedge clk);
            checks++;
            if (busy !== 1'b1) begin
                errors++;
                $display("ERR busy cycle %0d got %h exp %h", cnt, busy, 1'b1);
            end
            if (c_valid !== 1'b0 || c_out !== '0) begin
                errors++;
                $display("ERR c_valid/c_out during run got %h/%h exp 0", c_valid, c_out);
            end
            if (done === 1'b1) begin
                done_at = cnt;
            end
        end
        if (done_at == 0) begin
            errors++;
            $display("done never rose after start");
        end else if (done_at != RUN_CYCLES) begin
            errors++;
            $display("ERR done latency got %h exp %h", done_at, RUN_CYCLES);
        end
        @(posedge clk);
        #2;
        @(negedge clk);
        if (done !== 1'b0 || busy !== 1'b0) begin
            errors++;
            $display("ERR done/busy after run got %h/%h exp 0/0", done, busy);
        end
    endtask

    initial begin
        rst    = 1'b1;
        start  = 1'b0;
        p_wr   = '0;
        q_wr   = '0;
        r_wr   = '0;
        r_rd   = '0;
        errors = 0;
        checks = 0;
        $readmemh("tests/gemm_cases.mem", cases_mem);

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        checks++;
        if (busy !== 1'b0 || done !== 1'b0 || c_valid !== 1'b0) begin
            errors++;
            $display("ERR busy/done/c_valid after reset got %h/%h/%h exp 0/0/0",
                     busy, done, c_valid);
        end

        for (int c = 0; c < NUM_CASES; c++) begin
            load_case(c * CASE_WORDS);
            compare_r(c * CASE_WORDS + 2, "initial");
            run_engine();
            compare_r(c * CASE_WORDS + 4, "after run 1");
            run_engine();  // R not reloaded
            compare_r(c * CASE_WORDS + 6, "after run 2");
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/gemm_cases.mem
// per case 8 words of 256 bits: P entries 3..0, Q entries 3..0, R init (1:0, 3:2),
// R after run 1 (1:0, 3:2), R after run 2 (1:0, 3:2); lowest entry in low bits
// case 0: all ones
01010101_01010101_01010101_01010101
1111_1111_1111_1111
0
0
00000004_00000004_00000004_00000004_00000004_00000004_00000004_00000004
00000004_00000004_00000004_00000004_00000004_00000004_00000004_00000004
00000008_00000008_00000008_00000008_00000008_00000008_00000008_00000008
00000008_00000008_00000008_00000008_00000008_00000008_00000008_00000008
// case 1: negative activations
FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF
2222_2222_2222_2222
00000064_00000064_00000064_00000064_00000064_00000064_00000064_00000064
00000064_00000064_00000064_00000064_00000064_00000064_00000064_00000064
0000005C_0000005C_0000005C_0000005C_0000005C_0000005C_0000005C_0000005C
0000005C_0000005C_0000005C_0000005C_0000005C_0000005C_0000005C_0000005C
00000054_00000054_00000054_00000054_00000054_00000054_00000054_00000054
00000054_00000054_00000054_00000054_00000054_00000054_00000054_00000054
// case 2: values differ per block
FCFCFCFC_03030303_02020202_01010101
7777_3333_FFFF_1111
0
0
00000022_00000022_00000022_00000022_FFFFFFFE_FFFFFFFE_FFFFFFFE_FFFFFFFE
FFFFFFDA_FFFFFFDA_FFFFFFDA_FFFFFFDA_0000000E_0000000E_0000000E_0000000E
00000044_00000044_00000044_00000044_FFFFFFFC_FFFFFFFC_FFFFFFFC_FFFFFFFC
FFFFFFB4_FFFFFFB4_FFFFFFB4_FFFFFFB4_0000001C_0000001C_0000001C_0000001C
// case 3: values differ per element, sums wrap past the top
05FD0201_05FD0201_05FD0201_05FD0201
3E01_3E01_3E01_3E01
7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF
7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF_7FFFFFFF
80000029_7FFFFFF9_80000007_80000001_80000029_7FFFFFF9_80000007_80000001
80000029_7FFFFFF9_80000007_80000001_80000029_7FFFFFF9_80000007_80000001
80000053_7FFFFFF3_8000000F_80000003_80000053_7FFFFFF3_8000000F_80000003
80000053_7FFFFFF3_8000000F_80000003_80000053_7FFFFFF3_8000000F_80000003

//--- flist.f
logic/gemm_dims_pkg.sv
logic/gemm_ctrl_pkg.sv
logic/tile_buffer.sv
logic/tile_mac.sv
logic/block_sequencer.sv
logic/gemm_top.sv
tests/gemm_top_properties.sv
tests/gemm_top_tb.sv
